// File: hw/armCore_consts.svh
`ifndef ARMCORE_CONSTS_SVH
`define ARMCORE_CONSTS_SVH

// Datapath and register file geometry
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 4
`define REG_COUNT 16

// Fetch addressing
`define PC_RESET 32'h0000_0000
`define PC_STEP 4

`endif

// File: hw/armCorePkg.sv
`include "armCore_consts.svh"

package armCorePkg;

  // Data-processing opcodes in encoding order
  typedef enum logic [3:0] {
    aluAnd = 4'h0,
    aluEor = 4'h1,
    aluSub = 4'h2,
    aluRsb = 4'h3,
    aluAdd = 4'h4,
    aluAdc = 4'h5,
    aluSbc = 4'h6,
    aluRsc = 4'h7,
    aluTst = 4'h8,
    aluTeq = 4'h9,
    aluCmp = 4'hA,
    aluCmn = 4'hB,
    aluOrr = 4'hC,
    aluMov = 4'hD,
    aluBic = 4'hE,
    aluMvn = 4'hF
  } aluOp_e;

  typedef enum logic [3:0] {
    condEq = 4'h0,
    condNe = 4'h1,
    condCs = 4'h2,
    condCc = 4'h3,
    condMi = 4'h4,
    condPl = 4'h5,
    condVs = 4'h6,
    condVc = 4'h7,
    condHi = 4'h8,
    condLs = 4'h9,
    condGe = 4'hA,
    condLt = 4'hB,
    condGt = 4'hC,
    condLe = 4'hD,
    condAl = 4'hE,
    condNv = 4'hF
  } cond_e;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftType_e;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // Decode to execute
  typedef struct packed {
    logic                       valid;
    cond_e                      cond;
    aluOp_e                     aluOp;
    logic                       setFlags;
    logic                       writesRd;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`REG_ADDR_WIDTH-1:0] rn;
    logic [`REG_ADDR_WIDTH-1:0] rm;
    logic [`DATA_WIDTH-1:0]     rnValue;
    logic [`DATA_WIDTH-1:0]     rmValue;
    logic                       useImm;
    logic [`DATA_WIDTH-1:0]     immValue;
    logic                       immRotated;
    shiftType_e                 shiftType;
    logic [4:0]                 shiftAmount;
  } decodedOp_t;

  // Execute to result, also the retire record
  typedef struct packed {
    logic                       valid;
    logic                       condPassed;
    logic                       writesRd;
    logic [`REG_ADDR_WIDTH-1:0] rd;
    logic [`DATA_WIDTH-1:0]     data;
    flags_t                     flags;
  } execResult_t;

  typedef struct packed {
    logic [`REG_ADDR_WIDTH-1:0] addr;
    logic                       en;
  } regRead_t;

endpackage

// File: hw/fetchDecode.sv
`timescale 1ns/1ps
`include "armCore_consts.svh"

module fetchDecode (
  input  logic                   clk,
  input  logic                   rstN,
  output logic [`DATA_WIDTH-1:0] pc,
  input  logic [`DATA_WIDTH-1:0] instr,
  output armCorePkg::regRead_t   rnRead,
  output armCorePkg::regRead_t   rmRead,
  input  logic [`DATA_WIDTH-1:0] rnData,
  input  logic [`DATA_WIDTH-1:0] rmData,
  output armCorePkg::decodedOp_t decoded
);

  import armCorePkg::*;

  logic [`DATA_WIDTH-1:0]     instrQ;
  logic [`DATA_WIDTH-1:0]     instrPcQ;
  logic                       validQ;

  // Instruction fields
  aluOp_e                     opcode;
  logic                       immForm;
  logic [`REG_ADDR_WIDTH-1:0] rnIdx;
  logic [`REG_ADDR_WIDTH-1:0] rdIdx;
  logic [`REG_ADDR_WIDTH-1:0] rmIdx;
  logic [3:0]                 rotField;
  logic [7:0]                 imm8;

  logic [`DATA_WIDTH-1:0]     immZext;
  logic [2*`DATA_WIDTH-1:0]   immWide;
  logic [`DATA_WIDTH-1:0]     pcPlus8;
  logic                       isCompare;
  logic                       readsRn;

  // Fetch
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= `PC_RESET;
    end else begin
      pc <= pc + `DATA_WIDTH'(`PC_STEP);
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= 1'b1;
    end
  end

  // Instruction register with its address
  always_ff @(posedge clk) begin
    instrQ   <= instr;
    instrPcQ <= pc;
  end

  assign opcode   = aluOp_e'(instrQ[24:21]);
  assign immForm  = instrQ[25];
  assign rnIdx    = instrQ[19:16];
  assign rdIdx    = instrQ[15:12];
  assign rmIdx    = instrQ[3:0];
  assign rotField = instrQ[11:8];
  assign imm8     = instrQ[7:0];

  // Rotate right by twice the field, via a doubled word
  assign immZext = {{(`DATA_WIDTH-8){1'b0}}, imm8};
  assign immWide = {immZext, immZext} >> {rotField, 1'b0};

  assign isCompare = (opcode == aluTst) || (opcode == aluTeq) ||
                     (opcode == aluCmp) || (opcode == aluCmn);

  // MOV and MVN ignore Rn
  assign readsRn = (opcode != aluMov) && (opcode != aluMvn);

  assign rnRead.addr = rnIdx;
  assign rnRead.en   = validQ && readsRn;
  assign rmRead.addr = rmIdx;
  assign rmRead.en   = validQ && !immForm;

  // R15 reads as the instruction address plus two steps
  assign pcPlus8 = instrPcQ + `DATA_WIDTH'(2 * `PC_STEP);

  always_comb begin
    decoded.valid       = validQ;
    decoded.cond        = cond_e'(instrQ[31:28]);
    decoded.aluOp       = opcode;
    decoded.setFlags    = instrQ[20];
    decoded.writesRd    = !isCompare && (rdIdx != 4'hF);
    decoded.rd          = rdIdx;
    decoded.rn          = rnIdx;
    decoded.rm          = rmIdx;
    decoded.rnValue     = (rnIdx == 4'hF) ? pcPlus8 : rnData;
    decoded.rmValue     = (rmIdx == 4'hF) ? pcPlus8 : rmData;
    decoded.useImm      = immForm;
    decoded.immValue    = immWide[`DATA_WIDTH-1:0];
    decoded.immRotated  = (rotField != 4'h0);
    decoded.shiftType   = shiftType_e'(instrQ[6:5]);
    decoded.shiftAmount = instrQ[11:7];
  end

endmodule

// File: hw/aluExecute.sv
`timescale 1ns/1ps
`include "armCore_consts.svh"

module aluExecute (
  input  logic                    clk,
  input  logic                    rstN,
  input  armCorePkg::decodedOp_t  decoded,
  input  armCorePkg::execResult_t fwd,
  output armCorePkg::execResult_t result
);

  import armCorePkg::*;

  decodedOp_t             opQ;
  logic                   validQ;
  flags_t                 flagsQ;

  logic                   fwdHit;
  logic [`DATA_WIDTH-1:0] rnVal;
  logic [`DATA_WIDTH-1:0] rmVal;

  // Barrel shifter
  logic [4:0]             shAmt;
  logic [5:0]             lslIdx;
  logic [`DATA_WIDTH-1:0] shOut;
  logic                   shCarry;
  logic [`DATA_WIDTH-1:0] op2;
  logic                   op2Carry;

  // Adder and ALU
  logic [`DATA_WIDTH-1:0] addA;
  logic [`DATA_WIDTH-1:0] addB;
  logic                   addCin;
  logic                   isArith;
  logic [`DATA_WIDTH:0]   sum;
  logic                   overflow;
  logic [`DATA_WIDTH-1:0] aluOut;
  flags_t                 newFlags;
  logic                   passed;
  logic                   flagsWe;

  function automatic logic condPass(cond_e cond, flags_t f);
    logic pass;
    case (cond)
      condEq:  pass = f.z;
      condNe:  pass = !f.z;
      condCs:  pass = f.c;
      condCc:  pass = !f.c;
      condMi:  pass = f.n;
      condPl:  pass = !f.n;
      condVs:  pass = f.v;
      condVc:  pass = !f.v;
      condHi:  pass = f.c && !f.z;
      condLs:  pass = !f.c || f.z;
      condGe:  pass = (f.n == f.v);
      condLt:  pass = (f.n != f.v);
      condGt:  pass = !f.z && (f.n == f.v);
      condLe:  pass = f.z || (f.n != f.v);
      condAl:  pass = 1'b1;
      default: pass = 1'b0;
    endcase
    return pass;
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= decoded.valid;
    end
  end

  always_ff @(posedge clk) begin
    opQ <= decoded;
  end

  // Result stage bypass, R15 never matches since it is never written
  assign fwdHit = fwd.valid && fwd.condPassed && fwd.writesRd;
  assign rnVal  = (fwdHit && (fwd.rd == opQ.rn)) ? fwd.data : opQ.rnValue;
  assign rmVal  = (fwdHit && (fwd.rd == opQ.rm)) ? fwd.data : opQ.rmValue;

  assign shAmt  = opQ.shiftAmount;
  assign lslIdx = 6'd32 - {1'b0, shAmt};

  always_comb begin
    shOut   = rmVal;
    shCarry = flagsQ.c;
    case (opQ.shiftType)
      shLsl: begin
        if (shAmt != 5'd0) begin
          shOut   = rmVal << shAmt;
          shCarry = rmVal[lslIdx[4:0]];
        end
      end
      shLsr: begin
        // Amount 0 encodes 32
        if (shAmt == 5'd0) begin
          shOut   = '0;
          shCarry = rmVal[`DATA_WIDTH-1];
        end else begin
          shOut   = rmVal >> shAmt;
          shCarry = rmVal[shAmt - 5'd1];
        end
      end
      shAsr: begin
        if (shAmt == 5'd0) begin
          shOut   = {`DATA_WIDTH{rmVal[`DATA_WIDTH-1]}};
          shCarry = rmVal[`DATA_WIDTH-1];
        end else begin
          shOut   = $signed(rmVal) >>> shAmt;
          shCarry = rmVal[shAmt - 5'd1];
        end
      end
      default: begin
        // ROR #0 is RRX
        if (shAmt == 5'd0) begin
          shOut   = {flagsQ.c, rmVal[`DATA_WIDTH-1:1]};
          shCarry = rmVal[0];
        end else begin
          shOut   = (rmVal >> shAmt) | (rmVal << lslIdx);
          shCarry = rmVal[shAmt - 5'd1];
        end
      end
    endcase
  end

  // Immediate carry only changes with a nonzero rotation
  assign op2      = opQ.useImm ? opQ.immValue : shOut;
  assign op2Carry = opQ.useImm ? (opQ.immRotated ? opQ.immValue[`DATA_WIDTH-1] : flagsQ.c)
                               : shCarry;

  always_comb begin
    addA    = rnVal;
    addB    = op2;
    addCin  = 1'b0;
    isArith = 1'b1;
    case (opQ.aluOp)
      aluSub, aluCmp: begin
        addB   = ~op2;
        addCin = 1'b1;
      end
      aluRsb: begin
        addA   = op2;
        addB   = ~rnVal;
        addCin = 1'b1;
      end
      aluAdd, aluCmn: begin
        addCin = 1'b0;
      end
      aluAdc: begin
        addCin = flagsQ.c;
      end
      aluSbc: begin
        addB   = ~op2;
        addCin = flagsQ.c;
      end
      aluRsc: begin
        addA   = op2;
        addB   = ~rnVal;
        addCin = flagsQ.c;
      end
      default: begin
        isArith = 1'b0;
      end
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, addCin};
  assign overflow = (addA[`DATA_WIDTH-1] == addB[`DATA_WIDTH-1]) &&
                    (sum[`DATA_WIDTH-1] != addA[`DATA_WIDTH-1]);

  always_comb begin
    case (opQ.aluOp)
      aluAnd, aluTst: aluOut = rnVal & op2;
      aluEor, aluTeq: aluOut = rnVal ^ op2;
      aluOrr:         aluOut = rnVal | op2;
      aluMov:         aluOut = op2;
      aluBic:         aluOut = rnVal & ~op2;
      aluMvn:         aluOut = ~op2;
      default:        aluOut = sum[`DATA_WIDTH-1:0];
    endcase
  end

  // Logical ops keep V
  assign newFlags.n = aluOut[`DATA_WIDTH-1];
  assign newFlags.z = (aluOut == '0);
  assign newFlags.c = isArith ? sum[`DATA_WIDTH] : op2Carry;
  assign newFlags.v = isArith ? overflow : flagsQ.v;

  assign passed  = condPass(opQ.cond, flagsQ);
  assign flagsWe = validQ && passed && opQ.setFlags;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (flagsWe) begin
      flagsQ <= newFlags;
    end
  end

  always_comb begin
    result.valid      = validQ;
    result.condPassed = passed;
    result.writesRd   = opQ.writesRd;
    result.rd         = opQ.rd;
    result.data       = aluOut;
    result.flags      = flagsWe ? newFlags : flagsQ;
  end

endmodule

// File: hw/regWriteback.sv
`timescale 1ns/1ps
`include "armCore_consts.svh"

module regWriteback (
  input  logic                    clk,
  input  logic                    rstN,
  input  armCorePkg::execResult_t result,
  input  armCorePkg::regRead_t    rnRead,
  input  armCorePkg::regRead_t    rmRead,
  output logic [`DATA_WIDTH-1:0]  rnData,
  output logic [`DATA_WIDTH-1:0]  rmData,
  output armCorePkg::execResult_t commit
);

  import armCorePkg::*;

  execResult_t            resultQ;
  logic                   validQ;
  logic                   wrEn;
  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= result.valid;
    end
  end

  always_ff @(posedge clk) begin
    resultQ <= result;
  end

  always_comb begin
    commit       = resultQ;
    commit.valid = validQ;
  end

  // Only a passed, writing, valid record retires into the file
  assign wrEn = validQ && resultQ.condPassed && resultQ.writesRd;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[resultQ.rd] <= resultQ.data;
    end
  end

  // Same-cycle write wins over the stored value
  function automatic logic [`DATA_WIDTH-1:0] readPort(regRead_t rd);
    logic [`DATA_WIDTH-1:0] val;
    if (!rd.en) begin
      val = '0;
    end else if (wrEn && (resultQ.rd == rd.addr)) begin
      val = resultQ.data;
    end else begin
      val = regs[rd.addr];
    end
    return val;
  endfunction

  assign rnData = readPort(rnRead);
  assign rmData = readPort(rmRead);

endmodule

// File: hw/armCore.sv
`timescale 1ns/1ps
`include "armCore_consts.svh"

module armCore (
  input  logic                    clk,
  input  logic                    rstN,
  output logic [`DATA_WIDTH-1:0]  pc,
  input  logic [`DATA_WIDTH-1:0]  instr,
  output armCorePkg::execResult_t commit
);

  import armCorePkg::*;

  regRead_t               rnRead;
  regRead_t               rmRead;
  logic [`DATA_WIDTH-1:0] rnData;
  logic [`DATA_WIDTH-1:0] rmData;
  decodedOp_t             decoded;
  execResult_t            result;

  // Fetch and decode, reads through the result stage file
  fetchDecode i_fetchDecode (
    .clk     (clk),
    .rstN    (rstN),
    .pc      (pc),
    .instr   (instr),
    .rnRead  (rnRead),
    .rmRead  (rmRead),
    .rnData  (rnData),
    .rmData  (rmData),
    .decoded (decoded)
  );

  // Commit record doubles as the bypass source
  aluExecute i_aluExecute (
    .clk     (clk),
    .rstN    (rstN),
    .decoded (decoded),
    .fwd     (commit),
    .result  (result)
  );

  regWriteback i_regWriteback (
    .clk     (clk),
    .rstN    (rstN),
    .result  (result),
    .rnRead  (rnRead),
    .rmRead  (rmRead),
    .rnData  (rnData),
    .rmData  (rmData),
    .commit  (commit)
  );

endmodule

// File: verif/armCoreTbTable.svh
`ifndef ARMCORETBTABLE_SVH
`define ARMCORETBTABLE_SVH

// Each row holds the instruction word, condPassed, writesRd, rd, data and flags as nzcv
// Row k sits at address 4k with registers and flags zero before row 0
task automatic buildTable();
  // Rotated immediates
  addRow(encImm(condAl, aluMov, 0, 0, 1, 0, 8'hFF), 1, 1, 1, 32'h0000_00FF, 4'b0000);
  addRow(encImm(condAl, aluMov, 1, 0, 2, 4, 8'hFF), 1, 1, 2, 32'hFF00_0000, 4'b1010);
  addRow(encImm(condAl, aluMvn, 1, 0, 3, 0, 8'h00), 1, 1, 3, 32'hFFFF_FFFF, 4'b1010);
  addRow(encImm(condAl, aluAnd, 1, 3, 4, 1, 8'h0F), 1, 1, 4, 32'hC000_0003, 4'b1010);
  // Zero rotation keeps C
  addRow(encImm(condAl, aluEor, 1, 1, 5, 0, 8'hFF), 1, 1, 5, 32'h0000_0000, 4'b0110);
  addRow(encImm(condAl, aluOrr, 0, 1, 6, 12, 8'h01), 1, 1, 6, 32'h0000_01FF, 4'b0110);
  addRow(encImm(condAl, aluBic, 0, 6, 7, 0, 8'h0F), 1, 1, 7, 32'h0000_01F0, 4'b0110);
  // Shifter forms and carry out
  addRow(encReg(condAl, aluMov, 1, 0, 8, 4, shLsl, 1), 1, 1, 8, 32'h0000_0FF0, 4'b0000);
  addRow(encReg(condAl, aluMov, 1, 0, 9, 4, shLsr, 2), 1, 1, 9, 32'h0FF0_0000, 4'b0000);
  addRow(encReg(condAl, aluMov, 1, 0, 10, 8, shAsr, 2), 1, 1, 10, 32'hFFFF_0000, 4'b1000);
  addRow(encReg(condAl, aluMov, 1, 0, 11, 1, shRor, 4), 1, 1, 11, 32'hE000_0001, 4'b1010);
  // LSR #32, ASR #32 and RRX
  addRow(encReg(condAl, aluMov, 1, 0, 12, 0, shLsr, 4), 1, 1, 12, 32'h0000_0000, 4'b0110);
  addRow(encReg(condAl, aluMov, 1, 0, 13, 0, shAsr, 2), 1, 1, 13, 32'hFFFF_FFFF, 4'b1010);
  addRow(encReg(condAl, aluMov, 1, 0, 14, 0, shRor, 1), 1, 1, 14, 32'h8000_007F, 4'b1010);
  // Adder opcodes
  addRow(encImm(condAl, aluAdd, 1, 1, 1, 0, 8'h01), 1, 1, 1, 32'h0000_0100, 4'b0000);
  addRow(encImm(condAl, aluSub, 1, 1, 5, 12, 8'h01), 1, 1, 5, 32'h0000_0000, 4'b0110);
  addRow(encReg(condAl, aluAdd, 1, 3, 6, 0, shLsl, 3), 1, 1, 6, 32'hFFFF_FFFE, 4'b1010);
  addRow(encImm(condAl, aluAdc, 1, 1, 7, 0, 8'h00), 1, 1, 7, 32'h0000_0101, 4'b0000);
  addRow(encImm(condAl, aluMvn, 0, 0, 8, 1, 8'h02), 1, 1, 8, 32'h7FFF_FFFF, 4'b0000);
  addRow(encImm(condAl, aluAdd, 1, 8, 9, 0, 8'h01), 1, 1, 9, 32'h8000_0000, 4'b1001);
  addRow(encImm(condAl, aluSbc, 1, 1, 10, 0, 8'h01), 1, 1, 10, 32'h0000_00FE, 4'b0010);
  addRow(encImm(condAl, aluRsb, 1, 1, 11, 0, 8'h00), 1, 1, 11, 32'hFFFF_FF00, 4'b1000);
  addRow(encImm(condAl, aluRsc, 1, 1, 12, 12, 8'h02), 1, 1, 12, 32'h0000_00FF, 4'b0010);
  // Compare opcodes never write
  addRow(encImm(condAl, aluCmp, 1, 1, 0, 12, 8'h01), 1, 0, 0, 32'h0000_0000, 4'b0110);
  addRow(encReg(condAl, aluCmn, 1, 9, 0, 0, shLsl, 9), 1, 0, 0, 32'h0000_0000, 4'b0111);
  addRow(encImm(condAl, aluTst, 1, 3, 0, 1, 8'h02), 1, 0, 0, 32'h8000_0000, 4'b1011);
  addRow(encReg(condAl, aluTeq, 1, 1, 0, 0, shLsl, 1), 1, 0, 0, 32'h0000_0000, 4'b0111);
  // Predication with r2 surviving the failed MOVNES
  addRow(encImm(condNe, aluMov, 1, 0, 2, 0, 8'h55), 0, 1, 2, 32'h0000_0055, 4'b0111);
  addRow(encReg(condAl, aluMov, 0, 0, 4, 0, shLsl, 2), 1, 1, 4, 32'hFF00_0000, 4'b0111);
  addRow(encImm(condEq, aluAdd, 0, 1, 5, 0, 8'h01), 1, 1, 5, 32'h0000_0101, 4'b0111);
  addRow(encImm(condLt, aluMov, 0, 0, 6, 0, 8'h03), 1, 1, 6, 32'h0000_0003, 4'b0111);
  addRow(encImm(condNv, aluMov, 0, 0, 7, 0, 8'h09), 0, 1, 7, 32'h0000_0009, 4'b0111);
  // R15 reads and distance-two dependency
  addRow(encImm(condAl, aluAdd, 0, 15, 8, 0, 8'h00), 1, 1, 8, 32'h0000_0088, 4'b0111);
  addRow(encReg(condAl, aluMov, 0, 0, 9, 0, shLsl, 7), 1, 1, 9, 32'h0000_0101, 4'b0111);
  addRow(encReg(condAl, aluAdd, 0, 8, 10, 0, shLsl, 6), 1, 1, 10, 32'h0000_008B, 4'b0111);
  addRow(encReg(condAl, aluSub, 0, 10, 11, 0, shLsl, 15), 1, 1, 11, 32'hFFFF_FFF7, 4'b0111);
  // Rm taken straight from the result stage
  addRow(encReg(condAl, aluOrr, 0, 0, 12, 0, shLsl, 11), 1, 1, 12, 32'hFFFF_FFF7, 4'b0111);
endtask

`endif

// File: verif/armCoreTb.sv
`timescale 1ns/1ps
`include "armCore_consts.svh"

module armCoreTb;

  import armCorePkg::*;

  localparam int commitTimeout = 10;
  localparam int pipeLatency = 3;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] word;
    execResult_t            res;
    flags_t                 flags;
  } tableRow_t;

  logic                   clk;
  logic                   rstN;
  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] instr;
  execResult_t            commit;
  tableRow_t              rows[$];
  int                     cycleNo;

  armCore i_armCore (
    .clk    (clk),
    .rstN   (rstN),
    .pc     (pc),
    .instr  (instr),
    .commit (commit)
  );

  // Data-processing encodings for immediate and shifted register forms
  function automatic logic [31:0] encImm(cond_e cond, aluOp_e op, int s, int rn, int rd,
                                         int rot, logic [7:0] imm8);
    return {cond, 3'b001, op, s[0], rn[3:0], rd[3:0], rot[3:0], imm8};
  endfunction

  function automatic logic [31:0] encReg(cond_e cond, aluOp_e op, int s, int rn, int rd,
                                         int shamt, shiftType_e sh, int rm);
    return {cond, 3'b000, op, s[0], rn[3:0], rd[3:0], shamt[4:0], sh, 1'b0, rm[3:0]};
  endfunction

  task automatic addRow(logic [31:0] word, int passed, int writes, int rd,
                        logic [31:0] data, logic [3:0] nzcv);
    tableRow_t row;
    row.word           = word;
    row.res.valid      = 1'b1;
    row.res.condPassed = passed[0];
    row.res.writesRd   = writes[0];
    row.res.rd         = rd[3:0];
    row.res.data       = data;
    row.res.flags      = nzcv;
    row.flags          = nzcv;
    rows.push_back(row);
  endtask

  `include "armCoreTbTable.svh"

  // Past the table every address reads as an NV no-op
  function automatic logic [31:0] fetchWord(logic [31:0] addr);
    int          idx;
    logic [31:0] word;
    idx = int'(addr >> 2);
    if (idx < rows.size()) begin
      word = rows[idx].word;
    end else begin
      word = encImm(condNv, aluMov, 0, 0, 0, 0, 8'h00);
    end
    return word;
  endfunction

  task automatic reportMismatch(string name, int row, logic [31:0] got, logic [31:0] exp);
    $display("CHECK FAILED at %0t: row %0d %s got 0x%h expected 0x%h", $time, row, name, got,
             exp);
    $display("test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic reportError(string what);
    $display("%s at %0t", what, $time);
    $display("test failed");
    $fatal(1, "stopped on error");
  endtask

  // Flags are compared on their own
  task automatic checkResult(execResult_t got, execResult_t exp, int row);
    if (got.condPassed !== exp.condPassed) begin
      reportMismatch("commit.condPassed", row, got.condPassed, exp.condPassed);
    end
    if (got.writesRd !== exp.writesRd) begin
      reportMismatch("commit.writesRd", row, got.writesRd, exp.writesRd);
    end
    if (got.rd !== exp.rd) begin
      reportMismatch("commit.rd", row, got.rd, exp.rd);
    end
    if (got.data !== exp.data) begin
      reportMismatch("commit.data", row, got.data, exp.data);
    end
  endtask

  task automatic checkFlags(flags_t got, flags_t exp, int row);
    if (got !== exp) begin
      reportMismatch("commit.flags", row, got, exp);
    end
  endtask

  task automatic checkPc(logic [`DATA_WIDTH-1:0] got, logic [`DATA_WIDTH-1:0] exp, int row);
    if (got !== exp) begin
      reportMismatch("pc", row, got, exp);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Cycle 0 is the first cycle with rstN high
  always @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cycleNo <= 0;
    end else begin
      cycleNo <= cycleNo + 1;
    end
  end

  always @(posedge clk) begin
    #2;
    instr = fetchWord(pc);
  end

  initial begin
    int waitCount;
    rstN = 1'b0;
    buildTable();
    instr = fetchWord(`PC_RESET);
    repeat (8) @(posedge clk);
    #2;
    rstN = 1'b1;
    for (int r = 0; r < rows.size(); r++) begin
      waitCount = 0;
      @(negedge clk);
      while (commit.valid !== 1'b1) begin
        if (waitCount == commitTimeout) begin
          reportError($sformatf("no commit for row %0d within %0d cycles", r, commitTimeout));
        end
        waitCount++;
        @(negedge clk);
      end
      // One commit per cycle at a fixed latency from fetch
      if (cycleNo != r + pipeLatency) begin
        reportMismatch("commit cycle", r, cycleNo, r + pipeLatency);
      end
      // Fetch address of the current cycle
      checkPc(pc, `PC_RESET + `PC_STEP * (r + pipeLatency), r);
      checkResult(commit, rows[r].res, r);
      checkFlags(commit.flags, rows[r].flags, r);
    end
    $display("test passed");
    $finish;
  end

endmodule

// File: armCore.f
+incdir+hw
+incdir+verif
hw/armCorePkg.sv
hw/fetchDecode.sv
hw/aluExecute.sv
hw/regWriteback.sv
hw/armCore.sv
verif/armCoreTb.sv

// File: Bender.yml
package:
  name: armCore

sources:
  - include_dirs:
      - hw
    files:
      - hw/armCorePkg.sv
      - hw/fetchDecode.sv
      - hw/aluExecute.sv
      - hw/regWriteback.sv
      - hw/armCore.sv
  - target: simulation
    include_dirs:
      - hw
      - verif
    files:
      - verif/armCoreTb.sv
